//--- source/usart_defs.svh
// Widths and bit-timing constants shared by the whole USART
// Pulled in by both packages, so RTL files see them through the package types
`ifndef USART_DEFS_SVH
`define USART_DEFS_SVH

// ******************************
// Widths
// ******************************

// CPU bus width, also the widest character
`define USART_DATA_W 8

// Tick counter width, wide enough for the 64x divisor
`define USART_TICK_W 7

// ******************************
// Bit timing in ticks
// ******************************

// Last tick index of one bit for each baud factor
`define USART_DIV_1X  0
`define USART_DIV_16X 15
`define USART_DIV_64X 63

// Mid-bit tick index, used to verify the start bit and to time a half stop bit
`define USART_HALF_16X 7
`define USART_HALF_64X 31

`endif

//--- source/usartRegPkg.sv
// Types of the CPU-side register file
// Imported by every USART module that handles bus data or the control phase
`include "usart_defs.svh"

package usartRegPkg;

  // One bus byte, also used for buffers and characters
  typedef logic [`USART_DATA_W-1:0] usartData;

  // After reset the first control write is a mode byte, every later one is a command
  typedef enum logic
  {
    awaitMode,     // Next control write loads the mode register
    awaitCommand   // Next control write is a command
  } ctrlPhase;

endpackage

//--- source/serialFramePkg.sv
// Types describing the asynchronous line frame and its bit timing
// The divisor functions map a baud factor onto the tick constants of the defs header
`include "usart_defs.svh"

package serialFramePkg;

  // 0 selects 5 data bits, 3 selects 8 data bits
  typedef logic [1:0] charLength;

  // Encoding matches mode bits 1..0
  typedef enum logic [1:0] {factorSync, factor1x, factor16x, factor64x} baudFactor;

  // Encoding matches mode bits 7..6
  typedef enum logic [1:0] {stopInvalid, stopOne, stopOneHalf, stopTwo} stopBits;

  typedef logic [`USART_TICK_W-1:0] tickCount;  // Ticks within one bit
  typedef logic [2:0]               bitIndex;   // Data bit position

  typedef enum logic [2:0] {lineIdle, lineStart, lineData, lineParity, lineStop} frameState;

  // ******************************
  // Bit timing helpers
  // ******************************

  // Last tick index of a full bit, sync mode is not supported and runs as 1x
  function automatic tickCount bitDivisor(input baudFactor factor);
    case (factor)
      factor16x: return tickCount'(`USART_DIV_16X);
      factor64x: return tickCount'(`USART_DIV_64X);
      default:   return tickCount'(`USART_DIV_1X);
    endcase
  endfunction

  // Mid-bit tick index
  // At 1x there is no half bit so a single tick is used
  function automatic tickCount halfDivisor(input baudFactor factor);
    case (factor)
      factor16x: return tickCount'(`USART_HALF_16X);
      factor64x: return tickCount'(`USART_HALF_64X);
      default:   return tickCount'(`USART_DIV_1X);
    endcase
  endfunction

endpackage

//--- source/usartControl.sv
// CPU side of the USART with bus decode, mode and command registers and status
// Feeds the transmitter with a buffered character and takes finished characters
// from the receiver, keeping the ready and error flags the CPU polls
`timescale 1ns/1ns

module usartControl (
  input  logic                      RESET_Internal,  // System clock
  input  logic                      CLK,             // Asynchronous reset, active high
  input  logic                      csN,
  input  logic                      rdN,
  input  logic                      wrN,
  input  logic                      cd,              // High selects control or status
  input  usartRegPkg::usartData     dataIn,
  output usartRegPkg::usartData     dataOut,
  input  logic                      dsrN,
  input  logic                      ctsN,
  output logic                      txRdy,
  output logic                      rxReady,
  output logic                      rtsN,
  output logic                      dtrN,
  output logic                      txRequest,       // Held until the transmitter answers
  output usartRegPkg::usartData     txChar,
  input  logic                      txTaken,
  input  logic                      txEmpty,
  output logic                      sendBreak,
  input  logic                      rxDone,
  input  usartRegPkg::usartData     rxChar,
  input  logic                      frameErr,
  input  logic                      parityErr,
  output logic                      parityEnable,
  output logic                      parityEven,
  output serialFramePkg::charLength frameLength,
  output serialFramePkg::baudFactor frameFactor,
  output serialFramePkg::stopBits   frameStop
);
  import usartRegPkg::*;
  import serialFramePkg::*;

  logic     wrActive;       // Chip selected with write strobe low
  logic     wrLast;
  logic     wrEdge;         // First cycle of a write
  logic     rdActive;
  logic     rdLast;
  logic     dataReadEdge;   // First cycle of a receive buffer read
  logic     cmdWrite;       // Control write that lands in the command register
  ctrlPhase phase;
  usartData txBuffer;
  usartData rxBuffer;
  usartData status;
  logic     txBufferEmpty;
  logic     txEnable;
  logic     rxEnable;
  logic     frameErrFlag;
  logic     overrunFlag;
  logic     parityErrFlag;

  assign wrActive     = ~csN & ~wrN;
  assign wrEdge       = wrActive & ~wrLast;
  assign rdActive     = ~csN & ~rdN;
  assign dataReadEdge = rdActive & ~rdLast & ~cd;
  assign cmdWrite     = wrEdge & cd & (phase == awaitCommand);

  always_ff @(posedge RESET_Internal or posedge CLK)
  begin
    if (CLK)
    begin
      wrLast <= 1'b0;
      rdLast <= 1'b0;
    end
    else
    begin
      wrLast <= wrActive;
      rdLast <= rdActive;
    end
  end

  // ******************************
  // Mode and command registers
  // ******************************

  always_ff @(posedge RESET_Internal or posedge CLK)
  begin
    if (CLK)
    begin
      phase        <= awaitMode;
      stopSelectDefaults();
      rtsN         <= 1'b1;
      dtrN         <= 1'b1;
      sendBreak    <= 1'b0;
      rxEnable     <= 1'b0;
      txEnable     <= 1'b0;
    end
    else if (wrEdge && cd && phase == awaitMode)
    begin
      frameStop    <= stopBits'(dataIn[7:6]);
      parityEven   <= dataIn[5];
      parityEnable <= dataIn[4];
      frameLength  <= dataIn[3:2];
      frameFactor  <= baudFactor'(dataIn[1:0]);
      phase        <= awaitCommand;        // Everything after the mode byte is a command
    end
    else if (cmdWrite && dataIn[6])        // Internal reset drops back to the mode phase
    begin
      phase     <= awaitMode;
      rtsN      <= 1'b1;
      dtrN      <= 1'b1;
      sendBreak <= 1'b0;
      rxEnable  <= 1'b0;
      txEnable  <= 1'b0;
    end
    else if (cmdWrite)
    begin
      rtsN      <= ~dataIn[5];             // A set bit pulls the modem line low
      sendBreak <= dataIn[3];
      rxEnable  <= dataIn[2];
      dtrN      <= ~dataIn[1];
      txEnable  <= dataIn[0];
    end
  end

  // Mode fields come up as 8 bits, no parity, one stop bit at 1x
  task automatic stopSelectDefaults();
    frameStop    <= stopOne;
    parityEven   <= 1'b0;
    parityEnable <= 1'b0;
    frameLength  <= 2'd3;
    frameFactor  <= factor1x;
  endtask

  // ******************************
  // Flags and buffers
  // ******************************

  always_ff @(posedge RESET_Internal or posedge CLK)
  begin
    if (CLK)
    begin
      txBufferEmpty <= 1'b1;
      rxReady       <= 1'b0;
      frameErrFlag  <= 1'b0;
      overrunFlag   <= 1'b0;
      parityErrFlag <= 1'b0;
    end
    else
    begin
      if (wrEdge && !cd)
        txBufferEmpty <= 1'b0;             // A new write wins over a take in the same cycle
      else if (txTaken)
        txBufferEmpty <= 1'b1;
      if (rxDone && rxEnable)
        rxReady <= 1'b1;
      else if (dataReadEdge)
        rxReady <= 1'b0;
      if (cmdWrite && !dataIn[6] && dataIn[4])
      begin
        frameErrFlag  <= 1'b0;             // Error reset clears all three sticky flags
        overrunFlag   <= 1'b0;
        parityErrFlag <= 1'b0;
      end
      else if (rxDone)
      begin
        frameErrFlag  <= frameErrFlag | frameErr;
        parityErrFlag <= parityErrFlag | parityErr;
        overrunFlag   <= overrunFlag | rxReady;  // Previous character was never read
      end
    end
  end

  always_ff @(posedge RESET_Internal)
  begin
    if (wrEdge && !cd)
      txBuffer <= dataIn;
    if (rxDone)
      rxBuffer <= rxChar;                  // Overrun keeps the newest character
  end

  // Bit 6 would be sync detect and always reads zero here
  assign status = {~dsrN, 1'b0, frameErrFlag, overrunFlag, parityErrFlag,
                   txEmpty, rxReady, txBufferEmpty};

  assign dataOut   = rdActive ? (cd ? status : rxBuffer) : '0;
  assign txChar    = txBuffer;
  assign txRequest = ~txBufferEmpty & txEnable & ~ctsN;
  assign txRdy     = txBufferEmpty & txEnable & ~ctsN;

endmodule

//--- source/usartTransmitter.sv
// Transmit datapath that turns one buffered character into an async frame on txd
// Steps only on txTick and answers the control module with a one-cycle txTaken
`timescale 1ns/1ns

module usartTransmitter (
  input  logic                      RESET_Internal,  // System clock
  input  logic                      CLK,             // Asynchronous reset, active high
  input  logic                      txTick,
  input  logic                      txRequest,
  input  usartRegPkg::usartData     txChar,
  input  logic                      sendBreak,
  input  logic                      parityEnable,
  input  logic                      parityEven,
  input  serialFramePkg::charLength frameLength,
  input  serialFramePkg::baudFactor frameFactor,
  input  serialFramePkg::stopBits   frameStop,
  output logic                      txd,
  output logic                      txEmpty,
  output logic                      txTaken
);
  import usartRegPkg::*;
  import serialFramePkg::*;

  frameState state;
  tickCount  tickCnt;
  tickCount  bitDiv;        // Last tick of a full bit
  tickCount  segmentDiv;    // Last tick of the bit or stop segment being sent
  bitIndex   bitCnt;
  bitIndex   lastBit;
  usartData  shiftReg;      // Data goes out from bit 0
  logic      parityAcc;
  logic      stopSecond;    // Second stop segment is running
  logic      bitEnd;

  assign bitDiv     = bitDivisor(frameFactor);
  assign segmentDiv = (stopSecond && frameStop == stopOneHalf) ? halfDivisor(frameFactor)
                                                                : bitDiv;
  assign lastBit    = bitIndex'(frameLength) + 3'd4;
  assign bitEnd     = txTick && (tickCnt == segmentDiv);

  always_ff @(posedge RESET_Internal or posedge CLK)
  begin
    if (CLK)
    begin
      state      <= lineIdle;
      tickCnt    <= '0;
      bitCnt     <= '0;
      stopSecond <= 1'b0;
      txd        <= 1'b1;                  // Line idles high
      txEmpty    <= 1'b1;
      txTaken    <= 1'b0;
    end
    else
    begin
      txTaken <= 1'b0;
      if (txTick)
      begin
        tickCnt <= bitEnd ? '0 : tickCnt + 1'b1;
        case (state)
          lineIdle:
          begin
            txd        <= ~sendBreak;      // Break only shows between frames
            txEmpty    <= ~txRequest;
            tickCnt    <= '0;
            bitCnt     <= '0;
            stopSecond <= 1'b0;
            if (txRequest)
            begin
              txTaken <= 1'b1;
              state   <= lineStart;
            end
          end
          lineStart:
          begin
            txd <= 1'b0;
            if (bitEnd)
              state <= lineData;
          end
          lineData:
          begin
            txd <= shiftReg[0];
            if (bitEnd)
            begin
              bitCnt <= bitCnt + 1'b1;
              if (bitCnt == lastBit)
                state <= parityEnable ? lineParity : lineStop;
            end
          end
          lineParity:
          begin
            txd <= parityAcc;
            if (bitEnd)
              state <= lineStop;
          end
          lineStop:
          begin
            txd <= 1'b1;
            // 1.5 and 2 stop settings run a second segment, anything else is one bit
            if (bitEnd && !stopSecond && (frameStop == stopOneHalf || frameStop == stopTwo))
              stopSecond <= 1'b1;
            else if (bitEnd)
              state <= lineIdle;
          end
          default: state <= lineIdle;
        endcase
      end
    end
  end

  // Seeding with the inverse of the even flag turns the running XOR into the parity bit
  always_ff @(posedge RESET_Internal)
  begin
    if (txTick && state == lineIdle && txRequest)
    begin
      shiftReg  <= txChar;
      parityAcc <= ~parityEven;
    end
    else if (bitEnd && state == lineData)
    begin
      shiftReg  <= shiftReg >> 1;
      parityAcc <= parityAcc ^ shiftReg[0];
    end
  end

endmodule

//--- source/usartReceiver.sv
// Receive datapath that recovers async frames from rxd
// Synchronises the line, finds the start bit and samples once per bit on rxTick
// Each finished frame is reported with a one-cycle rxDone and its error bits
`timescale 1ns/1ns

module usartReceiver (
  input  logic                      RESET_Internal,  // System clock
  input  logic                      CLK,             // Asynchronous reset, active high
  input  logic                      rxTick,
  input  logic                      rxd,
  input  logic                      parityEnable,
  input  logic                      parityEven,
  input  serialFramePkg::charLength frameLength,
  input  serialFramePkg::baudFactor frameFactor,
  output logic                      rxDone,
  output usartRegPkg::usartData     rxChar,
  output logic                      frameErr,
  output logic                      parityErr
);
  import usartRegPkg::*;
  import serialFramePkg::*;

  logic      rxdMeta;
  logic      rxdSync;       // Line after two flops
  frameState state;
  tickCount  tickCnt;
  bitIndex   bitCnt;
  bitIndex   lastBit;
  usartData  rxShift;
  logic      parityAcc;
  logic      bitEnd;        // Sample point of a data, parity or stop bit
  logic      midStart;      // Mid-point of the start bit

  assign bitEnd   = rxTick && (tickCnt == bitDivisor(frameFactor));
  assign midStart = rxTick && (tickCnt == halfDivisor(frameFactor));
  assign lastBit  = bitIndex'(frameLength) + 3'd4;
  assign rxChar   = rxShift;

  // Both flops come out of reset high so no false start is seen
  always_ff @(posedge RESET_Internal or posedge CLK)
  begin
    if (CLK)
    begin
      rxdMeta <= 1'b1;
      rxdSync <= 1'b1;
    end
    else
    begin
      rxdMeta <= rxd;
      rxdSync <= rxdMeta;
    end
  end

  // ******************************
  // Frame state machine
  // ******************************

  always_ff @(posedge RESET_Internal or posedge CLK)
  begin
    if (CLK)
    begin
      state     <= lineIdle;
      tickCnt   <= '0;
      bitCnt    <= '0;
      rxDone    <= 1'b0;
      frameErr  <= 1'b0;
      parityErr <= 1'b0;
    end
    else
    begin
      rxDone <= 1'b0;
      if (rxTick)
      begin
        tickCnt <= tickCnt + 1'b1;
        case (state)
          lineIdle:
          begin
            tickCnt   <= '0;
            bitCnt    <= '0;
            parityErr <= 1'b0;             // Stays clear when parity is off
            if (!rxdSync)                  // At 1x there is no time to verify the start bit
              state <= (frameFactor == factor16x || frameFactor == factor64x) ? lineStart
                                                                              : lineData;
          end
          lineStart:
          begin
            if (midStart)
            begin
              tickCnt <= '0;               // Later samples land at the middle of each bit
              state   <= rxdSync ? lineIdle : lineData;
            end
          end
          lineData:
          begin
            if (bitEnd)
            begin
              tickCnt <= '0;
              bitCnt  <= bitCnt + 1'b1;
              if (bitCnt == lastBit)
                state <= parityEnable ? lineParity : lineStop;
            end
          end
          lineParity:
          begin
            if (bitEnd)
            begin
              tickCnt   <= '0;
              parityErr <= rxdSync != parityAcc;
              state     <= lineStop;
            end
          end
          lineStop:
          begin
            if (bitEnd)                    // Only the first stop bit is checked
            begin
              tickCnt  <= '0;
              rxDone   <= 1'b1;
              frameErr <= ~rxdSync;
              state    <= lineIdle;
            end
          end
          default: state <= lineIdle;
        endcase
      end
    end
  end

  // Shorter characters leave the upper bits at zero
  always_ff @(posedge RESET_Internal)
  begin
    if (rxTick && state == lineIdle)
    begin
      rxShift   <= '0;
      parityAcc <= ~parityEven;            // Expected parity bit once all data is in
    end
    else if (bitEnd && state == lineData)
    begin
      rxShift[bitCnt] <= rxdSync;
      parityAcc       <= parityAcc ^ rxdSync;
    end
  end

endmodule

//--- source/usartTop.sv
// Top level of the USART with the control module and both line datapaths
// Exposes the CPU bus, the tick enables and the modem lines
`timescale 1ns/1ns

module usartTop (
  input  logic                  RESET_Internal,  // System clock
  input  logic                  CLK,             // Asynchronous reset, active high
  input  logic                  csN,
  input  logic                  rdN,
  input  logic                  wrN,
  input  logic                  cd,
  input  usartRegPkg::usartData dataIn,
  output usartRegPkg::usartData dataOut,
  input  logic                  txTick,          // One pulse per transmit clock
  input  logic                  rxTick,          // One pulse per receive clock
  input  logic                  rxd,
  output logic                  txd,
  output logic                  txRdy,
  output logic                  txEmpty,
  output logic                  rxReady,
  input  logic                  dsrN,
  input  logic                  ctsN,
  output logic                  rtsN,
  output logic                  dtrN
);
  import usartRegPkg::*;
  import serialFramePkg::*;

  // Handshake between control and the transmitter
  logic      txRequest;
  logic      txTaken;
  usartData  txChar;
  logic      sendBreak;
  // Finished characters from the receiver
  logic      rxDone;
  usartData  rxChar;
  logic      frameErr;
  logic      parityErr;
  // Frame format from the mode register
  logic      parityEnable;
  logic      parityEven;
  charLength frameLength;
  baudFactor frameFactor;
  stopBits   frameStop;

  usartControl ctrl (
    .RESET_Internal(RESET_Internal), .CLK(CLK),
    .csN(csN), .rdN(rdN), .wrN(wrN), .cd(cd),
    .dataIn(dataIn), .dataOut(dataOut),
    .dsrN(dsrN), .ctsN(ctsN),
    .txRdy(txRdy), .rxReady(rxReady), .rtsN(rtsN), .dtrN(dtrN),
    .txRequest(txRequest), .txChar(txChar), .txTaken(txTaken), .txEmpty(txEmpty),
    .sendBreak(sendBreak),
    .rxDone(rxDone), .rxChar(rxChar), .frameErr(frameErr), .parityErr(parityErr),
    .parityEnable(parityEnable), .parityEven(parityEven),
    .frameLength(frameLength), .frameFactor(frameFactor), .frameStop(frameStop)
  );

  usartTransmitter tx (
    .RESET_Internal(RESET_Internal), .CLK(CLK), .txTick(txTick),
    .txRequest(txRequest), .txChar(txChar), .sendBreak(sendBreak),
    .parityEnable(parityEnable), .parityEven(parityEven),
    .frameLength(frameLength), .frameFactor(frameFactor), .frameStop(frameStop),
    .txd(txd), .txEmpty(txEmpty), .txTaken(txTaken)
  );

  usartReceiver rx (
    .RESET_Internal(RESET_Internal), .CLK(CLK), .rxTick(rxTick), .rxd(rxd),
    .parityEnable(parityEnable), .parityEven(parityEven),
    .frameLength(frameLength), .frameFactor(frameFactor),
    .rxDone(rxDone), .rxChar(rxChar), .frameErr(frameErr), .parityErr(parityErr)
  );

endmodule

//--- verif/usartTb.sv
// Directed testbench for the USART top level
// Drives the CPU bus and the rxd line, captures txd and compares against frames
// built here from the mode byte rules
`timescale 1ns/1ns

module usartTb;

  // Clock cycles per bit with a tick on every second cycle
  localparam int CYC_1X  = 2;
  localparam int CYC_16X = 32;
  localparam int CYC_64X = 128;
  // Two 64x frames, six 16x frames and one 1x frame of at most 12 bits each
  // Reset and bus traffic come on top as a fixed margin
  localparam int BUDGET  = 2 * 12 * CYC_64X + 6 * 12 * CYC_16X + 1 * 12 * CYC_1X + 5000;

  logic       RESET_Internal;
  logic       CLK;
  logic       csN, rdN, wrN, cd;
  logic [7:0] dataIn;
  logic [7:0] dataOut;
  logic       txTick, rxTick, rxd, txd;
  logic       txRdy, txEmpty, rxReady;
  logic       dsrN, ctsN, rtsN, dtrN;
  logic [31:0] lfsr = 32'h15cc_02dd;
  logic       modeLoaded;  // Set once the first mode byte is in

  usartTop uut (
    .RESET_Internal(RESET_Internal), .CLK(CLK),
    .csN(csN), .rdN(rdN), .wrN(wrN), .cd(cd), .dataIn(dataIn), .dataOut(dataOut),
    .txTick(txTick), .rxTick(rxTick), .rxd(rxd), .txd(txd),
    .txRdy(txRdy), .txEmpty(txEmpty), .rxReady(rxReady),
    .dsrN(dsrN), .ctsN(ctsN), .rtsN(rtsN), .dtrN(dtrN)
  );

  initial
  begin
    RESET_Internal = 1'b0;
    forever #10 RESET_Internal = ~RESET_Internal;
  end

  // Ticks are high on every second cycle
  initial
  begin
    txTick = 1'b0;
    rxTick = 1'b0;
    forever
    begin
      @(posedge RESET_Internal);
      #2;
      txTick = ~txTick;
      rxTick = txTick;
    end
  end

  initial
  begin
    repeat (BUDGET) @(posedge RESET_Internal);
    $display("Timeout: the tests did not finish in their time budget");
    $display("CHECKS FAILED");
    $fatal(1);
  end

  // ******************************
  // Helpers
  // ******************************

  task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
                            input string msg);
    if (actual !== expected)
    begin
      $display("FAILED at %0t ns: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit
  function automatic logic [7:0] randomBits(input int n);
    logic [7:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  // Parity bit that makes the ones count of the first len data bits even or odd
  function automatic logic expectedParity(input logic [7:0] data, input int len,
                                          input logic even);
    logic ones;
    ones = 1'b0;
    for (int i = 0; i < len; i++)
      ones = ones ^ data[i];
    return even ? ones : ~ones;
  endfunction

  task automatic waitCycles(input int n);
    repeat (n) @(posedge RESET_Internal);
    #5;                                     // Away from the edge where outputs settle
  endtask

  task automatic busWrite(input logic isCtrl, input logic [7:0] value);
    @(posedge RESET_Internal);
    #2;
    csN    = 1'b0;
    wrN    = 1'b0;
    cd     = isCtrl;
    dataIn = value;
    @(posedge RESET_Internal);
    #2;
    csN = 1'b1;
    wrN = 1'b1;
  endtask

  task automatic busRead(input logic isCtrl, output logic [7:0] value);
    @(posedge RESET_Internal);
    #2;
    csN = 1'b0;
    rdN = 1'b0;
    cd  = isCtrl;
    #5 value = dataOut;                     // dataOut is combinational
    @(posedge RESET_Internal);
    #2;
    csN = 1'b1;
    rdN = 1'b1;
  endtask

  // Leaves the command phase by internal reset when a mode is already loaded
  task automatic configure(input logic [7:0] mode, input logic [7:0] command);
    if (modeLoaded)
      busWrite(1'b1, 8'h40);
    busWrite(1'b1, mode);
    busWrite(1'b1, command);
    modeLoaded = 1'b1;
  endtask

  // Mid-bit sampling of one whole frame from its falling start edge
  task automatic catchFrame(input logic [7:0] data, input int len, input logic parEn,
                            input logic even, input int stops, input int cyc);
    logic parityBit;
    do waitCycles(1); while (txd !== 1'b0);
    waitCycles(cyc / 2);
    checkValue(8'(txd), 8'd0, "start bit level");
    for (int i = 0; i < len; i++)
    begin
      waitCycles(cyc);
      checkValue(8'(txd), 8'(data[i]), $sformatf("tx data bit %0d", i));
    end
    if (parEn)
    begin
      parityBit = expectedParity(data, len, even);
      waitCycles(cyc);
      checkValue(8'(txd), 8'(parityBit), "tx parity bit");
    end
    for (int s = 0; s < stops; s++)
    begin
      waitCycles(cyc);
      checkValue(8'(txd), 8'd1, "tx stop bit level");
    end
  endtask

  task automatic lineBit(input logic level, input int cyc);
    rxd = level;
    repeat (cyc) @(posedge RESET_Internal);
    #2;
  endtask

  // A low stop bit goes high again after three quarters of a bit
  task automatic sendFrame(input logic [7:0] data, input int len, input logic parEn,
                           input logic even, input logic badParity, input logic lowStop,
                           input int cyc);
    @(posedge RESET_Internal);
    #2;
    lineBit(1'b0, cyc);
    for (int i = 0; i < len; i++)
      lineBit(data[i], cyc);
    if (parEn)
      lineBit(expectedParity(data, len, even) ^ badParity, cyc);
    if (lowStop)
    begin
      lineBit(1'b0, cyc * 3 / 4);
      lineBit(1'b1, cyc / 4);
    end
    else
      lineBit(1'b1, cyc);
    rxd = 1'b1;
  endtask

  task automatic waitRxReady();
    do waitCycles(1); while (rxReady !== 1'b1);
    waitCycles(4);
  endtask

  // ******************************
  // Tests
  // ******************************

  task automatic testResetState();
    logic [7:0] st;
    checkValue(8'(txd), 8'd1, "txd after reset");
    checkValue(8'(txEmpty), 8'd1, "txEmpty after reset");
    checkValue(8'(txRdy), 8'd0, "txRdy after reset");
    checkValue(8'(rxReady), 8'd0, "rxReady after reset");
    checkValue(8'({rtsN, dtrN}), 8'(2'b11), "modem outputs after reset");
    busRead(1'b1, st);
    checkValue(st, 8'h05, "status after reset");
  endtask

  task automatic testTransmit();
    logic [7:0] ch;
    ch = randomBits(8);
    configure(8'h4E, 8'h01);                // 8 bits, no parity, 1 stop, 16x
    waitCycles(1);
    checkValue(8'(txRdy), 8'd1, "txRdy with empty buffer");
    busWrite(1'b0, ch);
    checkValue(8'(txRdy), 8'd0, "txRdy after data write");
    do waitCycles(1); while (txRdy !== 1'b1);
    checkValue(8'(txEmpty), 8'd0, "txEmpty while a frame is sent");
    catchFrame(ch, 8, 1'b0, 1'b0, 1, CYC_16X);
    do waitCycles(1); while (txEmpty !== 1'b1);
  endtask

  task automatic testFormats();
    logic [7:0] ch;
    ch = randomBits(5);
    configure(8'hF3, 8'h01);                // 5 bits, even parity, 2 stops, 64x
    busWrite(1'b0, ch);
    catchFrame(ch, 5, 1'b1, 1'b1, 2, CYC_64X);
    do waitCycles(1); while (txEmpty !== 1'b1);
    ch = randomBits(7);
    configure(8'hDB, 8'h01);                // 7 bits, odd parity, 2 stops, 64x
    busWrite(1'b0, ch);
    catchFrame(ch, 7, 1'b1, 1'b0, 2, CYC_64X);
    do waitCycles(1); while (txEmpty !== 1'b1);
    busWrite(1'b1, 8'h09);
    waitCycles(4);
    checkValue(8'(txd), 8'd0, "txd during break");
    busWrite(1'b1, 8'h01);
    waitCycles(4);
    checkValue(8'(txd), 8'd1, "txd after break");
  endtask

  task automatic receiveOne(input logic [7:0] mode, input int cyc);
    logic [7:0] ch;
    logic [7:0] rd;
    ch = randomBits(8);
    configure(mode, 8'h04);
    sendFrame(ch, 8, 1'b0, 1'b0, 1'b0, 1'b0, cyc);
    waitRxReady();
    busRead(1'b0, rd);
    checkValue(rd, ch, "received character");
    busRead(1'b1, rd);
    checkValue(8'(rd[1]), 8'd0, "rxReady after data read");
  endtask

  task automatic testErrors();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] rd;
    a = randomBits(8);
    b = randomBits(8);
    configure(8'h7E, 8'h04);                // 8 bits, even parity, 1 stop, 16x
    sendFrame(a, 8, 1'b1, 1'b1, 1'b1, 1'b0, CYC_16X);
    waitRxReady();
    busRead(1'b0, rd);
    busRead(1'b1, rd);
    checkValue(8'(rd[3]), 8'd1, "parity error flag");
    sendFrame(a, 8, 1'b1, 1'b1, 1'b0, 1'b1, CYC_16X);
    waitRxReady();
    busRead(1'b0, rd);
    busRead(1'b1, rd);
    checkValue(8'(rd[5]), 8'd1, "framing error flag");
    sendFrame(a, 8, 1'b1, 1'b1, 1'b0, 1'b0, CYC_16X);
    waitRxReady();
    sendFrame(b, 8, 1'b1, 1'b1, 1'b0, 1'b0, CYC_16X);
    waitCycles(CYC_16X);
    busRead(1'b1, rd);
    checkValue(8'(rd[4]), 8'd1, "overrun error flag");
    busRead(1'b0, rd);
    checkValue(rd, b, "buffer after overrun");
    busWrite(1'b1, 8'h14);                  // Error reset with the receiver left on
    busRead(1'b1, rd);
    checkValue(8'(rd[5:3]), 8'd0, "errors after error reset");
  endtask

  task automatic testCommands();
    logic [7:0] rd;
    busWrite(1'b1, 8'h22);
    waitCycles(1);
    checkValue(8'({rtsN, dtrN}), 8'(2'b00), "rtsN and dtrN driven low");
    @(posedge RESET_Internal);
    #2;
    dsrN = 1'b0;
    busRead(1'b1, rd);
    checkValue(8'(rd[7]), 8'd1, "status bit 7 with dsrN low");
    busWrite(1'b1, 8'h40);
    waitCycles(1);
    checkValue(8'({rtsN, dtrN}), 8'(2'b11), "modem outputs after internal reset");
    busWrite(1'b1, 8'h22);                  // Must be taken as a mode byte
    waitCycles(1);
    checkValue(8'({rtsN, dtrN}), 8'(2'b11), "first write after internal reset");
    busWrite(1'b1, 8'h22);
    waitCycles(1);
    checkValue(8'({rtsN, dtrN}), 8'(2'b00), "command after new mode byte");
  endtask

  initial
  begin
    CLK        = 1'b1;
    csN        = 1'b1;
    rdN        = 1'b1;
    wrN        = 1'b1;
    cd         = 1'b0;
    dataIn     = '0;
    rxd        = 1'b1;
    dsrN       = 1'b1;
    ctsN       = 1'b0;
    modeLoaded = 1'b0;
    repeat (10) @(posedge RESET_Internal);
    #2 CLK = 1'b0;
    waitCycles(2);
    testResetState();
    testTransmit();
    testFormats();
    receiveOne(8'h4E, CYC_16X);
    receiveOne(8'h4D, CYC_1X);
    testErrors();
    testCommands();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+source
source/usartRegPkg.sv
source/serialFramePkg.sv
source/usartControl.sv
source/usartTransmitter.sv
source/usartReceiver.sv
source/usartTop.sv
verif/usartTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --timing
TOP      = usartTb
FILELIST = build.f

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
